// ==== common/ingress_pkg.sv ====
/* Router ingress shared definitions */

package ingress_pkg;

    //////////////////////////////
    // Port set and bus geometry

    localparam int NUM_PORTS   = 2;
    localparam int BUS_BYTES   = 8;
    localparam int BUS_WIDTH   = BUS_BYTES * 8;
    localparam int PORT0_BYTES = 1;
    localparam int PORT1_BYTES = 4;

    //////////////////////////////
    // Buffer sizing

    localparam int MTU_BYTES = 64;
    localparam int MTU_WORDS = (MTU_BYTES + BUS_BYTES - 1) / BUS_BYTES;

    // Two MTUs per port, rounded up to a power of two so pointers wrap naturally
    localparam int BUF_DEPTH      = 2 ** $clog2(2 * MTU_WORDS);
    localparam int BUF_ADDR_WIDTH = $clog2(BUF_DEPTH);

    //////////////////////////////
    // Counters and tags

    localparam int PORT_ID_WIDTH     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
    localparam int COUNTER_WIDTH     = 32;
    localparam int BUS_PKT_CNT_WIDTH = 64;

    typedef logic [BUS_WIDTH-1:0]     bus_data_t;
    typedef logic [BUS_BYTES-1:0]     bus_keep_t;
    typedef logic [PORT_ID_WIDTH-1:0] port_id_t;
    typedef logic [COUNTER_WIDTH-1:0] counter_t;

    // Decided once per packet from the enable seen on its first beat
    typedef enum logic [1:0] {
        ADAPT_IDLE,
        ADAPT_PASS,
        ADAPT_DROP
    } adapt_state_e;

    typedef enum logic {
        FILL_WRITE,
        FILL_DISCARD
    } fill_state_e;

    typedef enum logic {
        SCHED_IDLE,
        SCHED_SEND
    } sched_state_e;

endpackage

// ==== ingress_port/port_width_adapter.sv ====
/* Narrow port to bus word adapter */

module port_width_adapter #(
    parameter int IN_BYTES = 1
) (
    input  logic                   AXIS_ARRAY,
    input  logic                   rst,
    input  logic                   in_valid,
    input  logic [IN_BYTES*8-1:0]  in_data,
    input  logic                   in_last,
    input  logic                   enable,
    output logic                   word_valid,
    output ingress_pkg::bus_data_t word_data,
    output ingress_pkg::bus_keep_t word_keep,
    output logic                   word_last,
    output logic                   drop_disabled
);
    import ingress_pkg::*;

    typedef logic [$clog2(BUS_BYTES+1)-1:0] fill_t;

    adapt_state_e state;
    fill_t        fill_bytes;
    logic         pass_beat;
    logic         word_full;
    logic         emit;

    // A beat goes through when the packet is already passing, or when it opens
    // a packet while the port is enabled
    assign pass_beat = in_valid && (state == ADAPT_PASS || (state == ADAPT_IDLE && enable));
    assign word_full = (fill_bytes + fill_t'(IN_BYTES)) == fill_t'(BUS_BYTES);
    assign emit      = pass_beat && (in_last || word_full);

    always_ff @(posedge AXIS_ARRAY) begin
        if (rst) begin
            state         <= ADAPT_IDLE;
            fill_bytes    <= '0;
            word_valid    <= 1'b0;
            drop_disabled <= 1'b0;
        end else begin
            word_valid    <= emit;
            drop_disabled <= 1'b0;
            if (pass_beat) begin
                fill_bytes <= emit ? '0 : fill_bytes + fill_t'(IN_BYTES);
            end
            if (in_valid) begin
                case (state)
                    ADAPT_IDLE: begin
                        if (!enable) begin
                            if (in_last) begin
                                drop_disabled <= 1'b1;
                            end else begin
                                state <= ADAPT_DROP;
                            end
                        end else if (!in_last) begin
                            state <= ADAPT_PASS;
                        end
                    end
                    ADAPT_PASS: begin
                        if (in_last) begin
                            state <= ADAPT_IDLE;
                        end
                    end
                    ADAPT_DROP: begin
                        if (in_last) begin
                            drop_disabled <= 1'b1;
                            state         <= ADAPT_IDLE;
                        end
                    end
                    default: state <= ADAPT_IDLE;
                endcase
            end
        end
    end

    // Beats fill the word from byte 0 upward, a fresh word starts zeroed
    always_ff @(posedge AXIS_ARRAY) begin
        if (pass_beat) begin
            if (fill_bytes == '0) begin
                word_data <= '0;
            end
            word_data[fill_bytes*8 +: IN_BYTES*8] <= in_data;
            word_keep <= bus_keep_t'((32'd1 << (fill_bytes + fill_t'(IN_BYTES))) - 32'd1);
            word_last <= in_last;
        end
    end

endmodule

// ==== ingress_port/port_counters.sv ====
/* Per-port packet counters */

module port_counters (
    input  logic                  AXIS_ARRAY,
    input  logic                  rst,
    input  logic                  clear,
    input  logic                  pkt_committed,
    input  logic                  drop_disabled,
    input  logic                  overflow,
    output ingress_pkg::counter_t pkt_cnt,
    output ingress_pkg::counter_t drop_cnt
);
    import ingress_pkg::*;

    logic [1:0] drop_inc;

    // Add with a ceiling at the all-ones value
    function automatic counter_t sat_add(input counter_t cnt, input logic [1:0] inc);
        logic [COUNTER_WIDTH:0] sum;
        sum = {1'b0, cnt} + (COUNTER_WIDTH+1)'(inc);
        return sum[COUNTER_WIDTH] ? {COUNTER_WIDTH{1'b1}} : sum[COUNTER_WIDTH-1:0];
    endfunction

    // A disabled-port drop and an overflow of an older packet can land together
    assign drop_inc = {1'b0, drop_disabled} + {1'b0, overflow};

    always_ff @(posedge AXIS_ARRAY) begin
        if (rst || clear) begin
            pkt_cnt  <= '0;
            drop_cnt <= '0;
        end else begin
            if (pkt_committed) begin
                pkt_cnt <= sat_add(pkt_cnt, 2'd1);
            end
            if (drop_inc != 2'd0) begin
                drop_cnt <= sat_add(drop_cnt, drop_inc);
            end
        end
    end

endmodule

// ==== ingress_buffer/packet_fifo.sv ====
/* Store-and-forward packet buffer */

module packet_fifo (
    input  logic                   AXIS_ARRAY,
    input  logic                   rst,
    input  logic                   word_valid,
    input  ingress_pkg::bus_data_t word_data,
    input  ingress_pkg::bus_keep_t word_keep,
    input  logic                   word_last,
    input  logic                   rd_en,
    output logic                   pkt_ready,
    output ingress_pkg::bus_data_t rd_data,
    output ingress_pkg::bus_keep_t rd_keep,
    output logic                   rd_last,
    output logic                   overflow,
    output logic                   pkt_committed
);
    import ingress_pkg::*;

    // One extra bit tells a full buffer from an empty one
    typedef logic [BUF_ADDR_WIDTH:0] ptr_t;

    bus_data_t   mem_data [BUF_DEPTH];
    bus_keep_t   mem_keep [BUF_DEPTH];
    logic        mem_last [BUF_DEPTH];

    fill_state_e fill_state;
    ptr_t        wr_ptr;
    ptr_t        commit_ptr;
    ptr_t        rd_ptr;
    ptr_t        pkt_count;
    logic        full;
    logic        wr_en;
    logic        commit;
    logic        release_pkt;

    // Occupancy includes the words already written for the packet in progress
    assign full        = (wr_ptr - rd_ptr) == ptr_t'(BUF_DEPTH);
    assign wr_en       = word_valid && fill_state == FILL_WRITE && !full;
    assign commit      = wr_en && word_last;
    assign release_pkt = rd_en && rd_last;

    //////////////////////////////
    // Write side

    always_ff @(posedge AXIS_ARRAY) begin
        if (rst) begin
            fill_state    <= FILL_WRITE;
            wr_ptr        <= '0;
            commit_ptr    <= '0;
            overflow      <= 1'b0;
            pkt_committed <= 1'b0;
        end else begin
            overflow      <= 1'b0;
            pkt_committed <= commit;
            if (word_valid) begin
                case (fill_state)
                    FILL_WRITE: begin
                        if (full) begin
                            // Throw away what this packet has written so far
                            wr_ptr <= commit_ptr;
                            if (word_last) begin
                                overflow <= 1'b1;
                            end else begin
                                fill_state <= FILL_DISCARD;
                            end
                        end else begin
                            wr_ptr <= wr_ptr + 1'b1;
                            if (word_last) begin
                                commit_ptr <= wr_ptr + 1'b1;
                            end
                        end
                    end
                    FILL_DISCARD: begin
                        if (word_last) begin
                            overflow   <= 1'b1;
                            fill_state <= FILL_WRITE;
                        end
                    end
                    default: fill_state <= FILL_WRITE;
                endcase
            end
        end
    end

    always_ff @(posedge AXIS_ARRAY) begin
        if (wr_en) begin
            mem_data[wr_ptr[BUF_ADDR_WIDTH-1:0]] <= word_data;
            mem_keep[wr_ptr[BUF_ADDR_WIDTH-1:0]] <= word_keep;
            mem_last[wr_ptr[BUF_ADDR_WIDTH-1:0]] <= word_last;
        end
    end

    //////////////////////////////
    // Read side

    always_ff @(posedge AXIS_ARRAY) begin
        if (rst) begin
            rd_ptr    <= '0;
            pkt_count <= '0;
        end else begin
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (commit && !release_pkt) begin
                pkt_count <= pkt_count + 1'b1;
            end else if (release_pkt && !commit) begin
                pkt_count <= pkt_count - 1'b1;
            end
        end
    end

    assign pkt_ready = pkt_count != '0;
    assign rd_data   = mem_data[rd_ptr[BUF_ADDR_WIDTH-1:0]];
    assign rd_keep   = mem_keep[rd_ptr[BUF_ADDR_WIDTH-1:0]];
    assign rd_last   = mem_last[rd_ptr[BUF_ADDR_WIDTH-1:0]];

endmodule

// ==== ingress_buffer/ingress_scheduler.sv ====
/* Round-robin packet scheduler */

module ingress_scheduler (
    input  logic                                AXIS_ARRAY,
    input  logic                                rst,
    input  logic [ingress_pkg::NUM_PORTS-1:0]   pkt_ready,
    input  ingress_pkg::bus_data_t              rd_data [ingress_pkg::NUM_PORTS],
    input  ingress_pkg::bus_keep_t              rd_keep [ingress_pkg::NUM_PORTS],
    input  logic [ingress_pkg::NUM_PORTS-1:0]   rd_last,
    input  logic                                bus_ready,
    output logic [ingress_pkg::NUM_PORTS-1:0]   rd_en,
    output logic                                bus_valid,
    output ingress_pkg::bus_data_t              bus_data,
    output ingress_pkg::bus_keep_t              bus_keep,
    output logic                                bus_last,
    output ingress_pkg::port_id_t               bus_port
);
    import ingress_pkg::*;

    sched_state_e state;
    port_id_t     grant;
    port_id_t     pick_port;
    logic         pick_valid;
    logic         fetched_last;
    logic         pop;

    // Search starts just after the port served last, that port itself comes last
    always_comb begin
        int idx;
        pick_valid = 1'b0;
        pick_port  = grant;
        for (int i = NUM_PORTS; i >= 1; i--) begin
            idx = (int'(grant) + i) % NUM_PORTS;
            if (pkt_ready[idx]) begin
                pick_valid = 1'b1;
                pick_port  = port_id_t'(idx);
            end
        end
    end

    // Fetch the next word whenever the output register is empty or draining
    assign pop = state == SCHED_SEND && !fetched_last && (!bus_valid || bus_ready);

    always_comb begin
        rd_en = '0;
        rd_en[grant] = pop;
    end

    always_ff @(posedge AXIS_ARRAY) begin
        if (rst) begin
            state        <= SCHED_IDLE;
            grant        <= '0;
            bus_valid    <= 1'b0;
            fetched_last <= 1'b0;
        end else begin
            case (state)
                SCHED_IDLE: begin
                    if (pick_valid) begin
                        grant        <= pick_port;
                        fetched_last <= 1'b0;
                        state        <= SCHED_SEND;
                    end
                end
                SCHED_SEND: begin
                    if (bus_valid && bus_ready) begin
                        bus_valid <= 1'b0;
                        if (bus_last) begin
                            state <= SCHED_IDLE;
                        end
                    end
                    if (pop) begin
                        bus_valid    <= 1'b1;
                        fetched_last <= rd_last[grant];
                    end
                end
                default: state <= SCHED_IDLE;
            endcase
        end
    end

    always_ff @(posedge AXIS_ARRAY) begin
        if (pop) begin
            bus_data <= rd_data[grant];
            bus_keep <= rd_keep[grant];
            bus_last <= rd_last[grant];
        end
    end

    // Grant only changes in idle, so it stays steady under a pending word
    assign bus_port = grant;

endmodule

// ==== hdl/router_ingress.sv ====
/* Router packet ingress */

module router_ingress (
    input  logic                                            AXIS_ARRAY,
    input  logic                                            rst,
    input  logic                                            p0_valid,
    input  logic [ingress_pkg::PORT0_BYTES*8-1:0]           p0_data,
    input  logic                                            p0_last,
    input  logic                                            p1_valid,
    input  logic [ingress_pkg::PORT1_BYTES*8-1:0]           p1_data,
    input  logic                                            p1_last,
    input  logic [ingress_pkg::NUM_PORTS-1:0]               port_enable,
    input  logic [ingress_pkg::NUM_PORTS-1:0]               cnt_clear,
    input  logic                                            bus_ready,
    input  logic                                            bus_pkt_cnt_clear,
    output logic                                            bus_valid,
    output ingress_pkg::bus_data_t                          bus_data,
    output ingress_pkg::bus_keep_t                          bus_keep,
    output logic                                            bus_last,
    output ingress_pkg::port_id_t                           bus_port,
    output logic [ingress_pkg::BUS_PKT_CNT_WIDTH-1:0]       bus_pkt_cnt,
    output ingress_pkg::counter_t                           pkt_cnt [ingress_pkg::NUM_PORTS],
    output ingress_pkg::counter_t                           drop_cnt [ingress_pkg::NUM_PORTS],
    output logic [ingress_pkg::NUM_PORTS-1:0]               buf_overflow
);
    import ingress_pkg::*;

    logic [NUM_PORTS-1:0] word_valid;
    bus_data_t            word_data [NUM_PORTS];
    bus_keep_t            word_keep [NUM_PORTS];
    logic [NUM_PORTS-1:0] word_last;
    logic [NUM_PORTS-1:0] drop_disabled;
    logic [NUM_PORTS-1:0] pkt_committed;
    logic [NUM_PORTS-1:0] pkt_ready;
    bus_data_t            rd_data [NUM_PORTS];
    bus_keep_t            rd_keep [NUM_PORTS];
    logic [NUM_PORTS-1:0] rd_last;
    logic [NUM_PORTS-1:0] rd_en;

    //////////////////////////////
    // Width adapters

    port_width_adapter #(.IN_BYTES(PORT0_BYTES)) u_adapter_p0 (
        .AXIS_ARRAY    (AXIS_ARRAY),
        .rst           (rst),
        .in_valid      (p0_valid),
        .in_data       (p0_data),
        .in_last       (p0_last),
        .enable        (port_enable[0]),
        .word_valid    (word_valid[0]),
        .word_data     (word_data[0]),
        .word_keep     (word_keep[0]),
        .word_last     (word_last[0]),
        .drop_disabled (drop_disabled[0])
    );

    port_width_adapter #(.IN_BYTES(PORT1_BYTES)) u_adapter_p1 (
        .AXIS_ARRAY    (AXIS_ARRAY),
        .rst           (rst),
        .in_valid      (p1_valid),
        .in_data       (p1_data),
        .in_last       (p1_last),
        .enable        (port_enable[1]),
        .word_valid    (word_valid[1]),
        .word_data     (word_data[1]),
        .word_keep     (word_keep[1]),
        .word_last     (word_last[1]),
        .drop_disabled (drop_disabled[1])
    );

    //////////////////////////////
    // Per-port buffers and counters

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        packet_fifo u_packet_fifo (
            .AXIS_ARRAY    (AXIS_ARRAY),
            .rst           (rst),
            .word_valid    (word_valid[p]),
            .word_data     (word_data[p]),
            .word_keep     (word_keep[p]),
            .word_last     (word_last[p]),
            .rd_en         (rd_en[p]),
            .pkt_ready     (pkt_ready[p]),
            .rd_data       (rd_data[p]),
            .rd_keep       (rd_keep[p]),
            .rd_last       (rd_last[p]),
            .overflow      (buf_overflow[p]),
            .pkt_committed (pkt_committed[p])
        );

        port_counters u_port_counters (
            .AXIS_ARRAY    (AXIS_ARRAY),
            .rst           (rst),
            .clear         (cnt_clear[p]),
            .pkt_committed (pkt_committed[p]),
            .drop_disabled (drop_disabled[p]),
            .overflow      (buf_overflow[p]),
            .pkt_cnt       (pkt_cnt[p]),
            .drop_cnt      (drop_cnt[p])
        );
    end

    ingress_scheduler u_ingress_scheduler (
        .AXIS_ARRAY (AXIS_ARRAY),
        .rst        (rst),
        .pkt_ready  (pkt_ready),
        .rd_data    (rd_data),
        .rd_keep    (rd_keep),
        .rd_last    (rd_last),
        .bus_ready  (bus_ready),
        .rd_en      (rd_en),
        .bus_valid  (bus_valid),
        .bus_data   (bus_data),
        .bus_keep   (bus_keep),
        .bus_last   (bus_last),
        .bus_port   (bus_port)
    );

    // Packets delivered on the bus, held at the top when it saturates
    always_ff @(posedge AXIS_ARRAY) begin
        if (rst || bus_pkt_cnt_clear) begin
            bus_pkt_cnt <= '0;
        end else if (bus_valid && bus_ready && bus_last && !(&bus_pkt_cnt)) begin
            bus_pkt_cnt <= bus_pkt_cnt + 1'b1;
        end
    end

endmodule

// ==== verification/router_ingress_tb.sv ====
/* Router ingress testbench */

module router_ingress_tb;
    import ingress_pkg::*;

    localparam int DRAIN_TIMEOUT = 3000;
    localparam int DROP_TIMEOUT  = 200;
    localparam int NUM_ROWS      = 10;

    // Each row is one packet and a row with pair set goes out together with the next row
    typedef struct packed {
        int port;
        int len;
        bit en;
        bit stall;
        bit drop;
        bit pair;
    } row_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        //  port len en stall drop pair
        '{0, 13, 1, 0, 0, 0},
        '{0, 24, 1, 0, 0, 1},
        '{1, 40, 1, 0, 0, 0},
        '{1,  8, 1, 0, 0, 1},
        '{0,  5, 1, 0, 0, 0},
        '{0, 10, 0, 0, 1, 0},
        '{0,  7, 1, 0, 0, 0},
        '{1, 64, 1, 1, 0, 0},
        '{1, 64, 1, 1, 0, 0},
        '{1, 64, 1, 1, 1, 0}
    };

    logic                         AXIS_ARRAY;
    logic                         rst;
    logic                         p0_valid;
    logic [PORT0_BYTES*8-1:0]     p0_data;
    logic                         p0_last;
    logic                         p1_valid;
    logic [PORT1_BYTES*8-1:0]     p1_data;
    logic                         p1_last;
    logic [NUM_PORTS-1:0]         port_enable;
    logic [NUM_PORTS-1:0]         cnt_clear;
    logic                         bus_ready;
    logic                         bus_pkt_cnt_clear;
    logic                         bus_valid;
    bus_data_t                    bus_data;
    bus_keep_t                    bus_keep;
    logic                         bus_last;
    port_id_t                     bus_port;
    logic [BUS_PKT_CNT_WIDTH-1:0] bus_pkt_cnt;
    counter_t                     pkt_cnt [NUM_PORTS];
    counter_t                     drop_cnt [NUM_PORTS];
    logic [NUM_PORTS-1:0]         buf_overflow;

    // Reference model state
    int         exp_len [NUM_PORTS][$];
    logic [7:0] exp_bytes [NUM_PORTS][$];
    int         commit_exp [NUM_PORTS];
    int         drop_exp [NUM_PORTS];
    int         ovf_exp [NUM_PORTS];
    int         ovf_seen [NUM_PORTS];
    int         total_exp;
    logic       in_pkt;
    int         rx_port;
    int         rx_left;
    logic       held_valid;
    logic       bus_stall;
    logic [31:0] lfsr;

    router_ingress u_router_ingress (.*);

    initial begin
        AXIS_ARRAY = 1'b0;
        forever #4 AXIS_ARRAY = ~AXIS_ARRAY;
    end

    //////////////////////////////
    // Helpers

    function automatic logic [7:0] pkt_byte(input int n, input int k);
        return 8'((n * 16 + k) % 256);
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s is %h, expected %h", name, actual, expected);
            abort_run();
        end
    endtask

    // Adds a row to the model so that only packets that survive are expected on the bus
    task automatic prepare_row(input int r);
        int p;
        p = ROWS[r].port;
        port_enable[p] = ROWS[r].en;
        if (ROWS[r].drop) begin
            drop_exp[p]++;
            if (ROWS[r].en) begin
                ovf_exp[p]++;
            end
        end else begin
            commit_exp[p]++;
            total_exp++;
            exp_len[p].push_back(ROWS[r].len);
            for (int k = 0; k < ROWS[r].len; k++) begin
                exp_bytes[p].push_back(pkt_byte(r, k));
            end
        end
    endtask

    task automatic send_packet(input int port, input int n, input int len);
        if (port == 0) begin
            for (int k = 0; k < len; k++) begin
                @(negedge AXIS_ARRAY);
                p0_valid = 1'b1;
                p0_data  = pkt_byte(n, k);
                p0_last  = (k == len - 1);
            end
            @(negedge AXIS_ARRAY);
            p0_valid = 1'b0;
            p0_last  = 1'b0;
        end else begin
            // Earlier bytes sit in the lower lanes of a wide beat
            for (int k = 0; k < len; k += PORT1_BYTES) begin
                @(negedge AXIS_ARRAY);
                p1_valid = 1'b1;
                p1_data  = {pkt_byte(n, k + 3), pkt_byte(n, k + 2),
                            pkt_byte(n, k + 1), pkt_byte(n, k)};
                p1_last  = (k + PORT1_BYTES >= len);
            end
            @(negedge AXIS_ARRAY);
            p1_valid = 1'b0;
            p1_last  = 1'b0;
        end
    endtask

    task automatic wait_drained();
        for (int i = 0; i < DRAIN_TIMEOUT; i++) begin
            @(negedge AXIS_ARRAY);
            if (!in_pkt && exp_len[0].size() == 0 && exp_len[1].size() == 0) begin
                return;
            end
        end
        $display("Timed out waiting for the expected packets to leave the bus");
        abort_run();
    endtask

    task automatic wait_drop(input int port);
        for (int i = 0; i < DROP_TIMEOUT; i++) begin
            @(negedge AXIS_ARRAY);
            if (drop_cnt[port] == counter_t'(drop_exp[port])) begin
                return;
            end
        end
        $display("Timed out waiting for the drop counter of port %0d to count a drop", port);
        abort_run();
    endtask

    task automatic check_counters();
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value($sformatf("pkt_cnt[%0d]", p), pkt_cnt[p], commit_exp[p]);
            check_value($sformatf("drop_cnt[%0d]", p), drop_cnt[p], drop_exp[p]);
            check_value($sformatf("buf_overflow[%0d] pulses", p), ovf_seen[p], ovf_exp[p]);
        end
        check_value("bus_pkt_cnt", bus_pkt_cnt, total_exp);
    endtask

    //////////////////////////////
    // Bus side

    always @(negedge AXIS_ARRAY) begin
        if (bus_stall) begin
            bus_ready = 1'b0;
        end else begin
            bus_ready = lfsr[0];
            lfsr      = lfsr_step(lfsr);
        end
    end

    always @(posedge AXIS_ARRAY) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!rst && buf_overflow[p]) begin
                ovf_seen[p]++;
            end
        end
    end

    // A word offered while ready is low has to stay offered until it transfers
    always @(posedge AXIS_ARRAY) begin
        if (!rst && held_valid) begin
            check_value("bus_valid", bus_valid, 1'b1);
        end
        held_valid = !rst && bus_valid && !bus_ready;
    end

    // Each transferred word is matched against the head of its port's queue
    always @(posedge AXIS_ARRAY) begin
        int nbytes;
        if (!rst && bus_valid && bus_ready) begin
            if (!in_pkt) begin
                rx_port = int'(bus_port);
                if (exp_len[rx_port].size() == 0) begin
                    $display("A packet came out for port %0d when none was expected", rx_port);
                    abort_run();
                end
                rx_left = exp_len[rx_port].pop_front();
                in_pkt  = 1'b1;
            end
            check_value("bus_port", bus_port, rx_port);
            nbytes = (rx_left > BUS_BYTES) ? BUS_BYTES : rx_left;
            check_value("bus_keep", bus_keep, bus_keep_t'((1 << nbytes) - 1));
            check_value("bus_last", bus_last, rx_left <= BUS_BYTES);
            for (int i = 0; i < nbytes; i++) begin
                check_value($sformatf("bus_data byte %0d", i), bus_data[i*8 +: 8],
                            exp_bytes[rx_port].pop_front());
            end
            rx_left -= nbytes;
            if (rx_left == 0) begin
                in_pkt = 1'b0;
            end
        end
    end

    //////////////////////////////
    // Main sequence

    initial begin
        int r;
        int group;
        rst = 1'b1;
        p0_valid = 1'b0;
        p0_data = '0;
        p0_last = 1'b0;
        p1_valid = 1'b0;
        p1_data = '0;
        p1_last = 1'b0;
        port_enable = '1;
        cnt_clear = '0;
        bus_ready = 1'b0;
        bus_pkt_cnt_clear = 1'b0;
        bus_stall = 1'b1;
        lfsr = 32'h59d4;
        in_pkt = 1'b0;
        held_valid = 1'b0;
        total_exp = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            commit_exp[p] = 0;
            drop_exp[p] = 0;
            ovf_exp[p] = 0;
            ovf_seen[p] = 0;
        end
        repeat (4) @(negedge AXIS_ARRAY);
        rst = 1'b0;

        r = 0;
        while (r < NUM_ROWS) begin
            group = ROWS[r].pair ? 2 : 1;
            bus_stall <= ROWS[r].stall;
            for (int g = 0; g < group; g++) begin
                prepare_row(r + g);
            end
            if (group == 2) begin
                fork
                    send_packet(ROWS[r].port, r, ROWS[r].len);
                    send_packet(ROWS[r + 1].port, r + 1, ROWS[r + 1].len);
                join
            end else begin
                send_packet(ROWS[r].port, r, ROWS[r].len);
            end
            for (int g = 0; g < group; g++) begin
                if (ROWS[r + g].drop) begin
                    wait_drop(ROWS[r + g].port);
                end
            end
            // Stalled rows pile up in the buffer until the bus opens again
            if (!ROWS[r].stall) begin
                wait_drained();
                check_counters();
            end
            r += group;
        end

        bus_stall <= 1'b0;
        wait_drained();
        // Idle window in which a stray packet would still reach the receiver
        repeat (40) @(negedge AXIS_ARRAY);
        check_counters();

        bus_pkt_cnt_clear = 1'b1;
        cnt_clear = '1;
        @(negedge AXIS_ARRAY);
        bus_pkt_cnt_clear = 1'b0;
        cnt_clear = '0;
        check_value("bus_pkt_cnt", bus_pkt_cnt, 0);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value($sformatf("pkt_cnt[%0d]", p), pkt_cnt[p], 0);
            check_value($sformatf("drop_cnt[%0d]", p), drop_cnt[p], 0);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== sources.f ====
common/ingress_pkg.sv
ingress_port/port_width_adapter.sv
ingress_port/port_counters.sv
ingress_buffer/packet_fifo.sv
ingress_buffer/ingress_scheduler.sv
hdl/router_ingress.sv
verification/router_ingress_tb.sv

// ==== Bender.yml ====
package:
  name: router_ingress

sources:
  - files:
      - common/ingress_pkg.sv
      - ingress_port/port_width_adapter.sv
      - ingress_port/port_counters.sv
      - ingress_buffer/packet_fifo.sv
      - ingress_buffer/ingress_scheduler.sv
      - hdl/router_ingress.sv
  - target: simulation
    files:
      - verification/router_ingress_tb.sv
